// File: rtl/dma_cfg_pkg.sv
// ----------------------------------------------------------------------
// sizing constants and byte-mask helpers for the DMA realignment path
// shared by the read side, the write side and the lane FIFOs
// ----------------------------------------------------------------------

package dma_cfg_pkg;

    // bus geometry, one word per beat
    localparam int DATA_WIDTH     = 32;
    localparam int BYTE_WIDTH     = 8;
    localparam int BYTES_PER_BEAT = DATA_WIDTH / BYTE_WIDTH;

    // byte offsets, tailers and shifts address one lane
    localparam int OFFSET_WIDTH   = $clog2(BYTES_PER_BEAT);

    // three entries per lane keep the pipe running without bubbles
    localparam int BUFFER_DEPTH   = 3;
    localparam int FIFO_PTR_WIDTH = $clog2(BUFFER_DEPTH);
    localparam int FIFO_CNT_WIDTH = $clog2(BUFFER_DEPTH + 1);

    // burst length counter on the write side
    localparam int BEAT_CNT_WIDTH = 8;

    // ------------------------------------------------------------------
    // mask helpers
    // ------------------------------------------------------------------
    // lanes from the start offset upward are valid in a first beat
    function automatic logic [BYTES_PER_BEAT-1:0] first_mask(
        input logic [OFFSET_WIDTH-1:0] offset
    );
        return {BYTES_PER_BEAT{1'b1}} << offset;
    endfunction

    // only the low tailer lanes are valid in a last beat
    // a tailer of zero means the beat ends on a word boundary
    function automatic logic [BYTES_PER_BEAT-1:0] last_mask(
        input logic [OFFSET_WIDTH-1:0] tailer
    );
        logic [BYTES_PER_BEAT-1:0] mask;
        mask = {BYTES_PER_BEAT{1'b1}};
        if (tailer != '0) begin
            mask = mask >> (BYTES_PER_BEAT - int'(tailer));
        end
        return mask;
    endfunction

endpackage

// File: rtl/dma_chan_pkg.sv
// ----------------------------------------------------------------------
// port structs of the DMA data path: read and write beats plus the
// per-request alignment descriptors held by the backend during a burst
// ----------------------------------------------------------------------

package dma_chan_pkg;

    // one flag per byte lane
    typedef logic [dma_cfg_pkg::BYTES_PER_BEAT-1:0] lane_mask_t;

    // a bus word seen as byte lanes, lane 0 holds the low byte
    typedef logic [dma_cfg_pkg::BYTES_PER_BEAT-1:0][dma_cfg_pkg::BYTE_WIDTH-1:0] lane_data_t;

    // read channel beat
    typedef struct packed {
        lane_data_t data;
        logic       last;
    } r_beat_t;

    // read side alignment of one request
    typedef struct packed {
        // first valid byte in the first read beat
        logic [dma_cfg_pkg::OFFSET_WIDTH-1:0] offset;
        // valid bytes in the last read beat, zero for a full word
        logic [dma_cfg_pkg::OFFSET_WIDTH-1:0] tailer;
        // rotation from read to write alignment, (w_offset - r_offset) mod 4
        logic [dma_cfg_pkg::OFFSET_WIDTH-1:0] shift;
    } r_align_t;

    // write side alignment of one request
    typedef struct packed {
        logic [dma_cfg_pkg::OFFSET_WIDTH-1:0]   offset;
        logic [dma_cfg_pkg::OFFSET_WIDTH-1:0]   tailer;
        // number of write beats in the burst, counter is bypassed when single
        logic [dma_cfg_pkg::BEAT_CNT_WIDTH-1:0] num_beats;
        // whole transfer fits in one write beat
        logic                                   single;
    } w_align_t;

    // write channel beat
    typedef struct packed {
        lane_data_t data;
        lane_mask_t strb;
        logic       last;
    } w_beat_t;

endpackage

// File: rtl/dma_byte_fifo.sv
// ----------------------------------------------------------------------
// single byte lane of the realignment buffer
// circular buffer without fall-through, data shows one cycle after push
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module dma_byte_fifo (
    input  logic                               clk_i,
    input  logic                               rst_ni,
    input  logic                               push_i,
    input  logic [dma_cfg_pkg::BYTE_WIDTH-1:0] data_i,
    input  logic                               pop_i,
    output logic [dma_cfg_pkg::BYTE_WIDTH-1:0] data_o,
    output logic                               full_o,
    output logic                               empty_o
);

    // storage
    logic [dma_cfg_pkg::BYTE_WIDTH-1:0]     mem_q [dma_cfg_pkg::BUFFER_DEPTH];
    logic [dma_cfg_pkg::FIFO_PTR_WIDTH-1:0] wr_ptr_q;
    logic [dma_cfg_pkg::FIFO_PTR_WIDTH-1:0] rd_ptr_q;
    logic [dma_cfg_pkg::FIFO_CNT_WIDTH-1:0] fill_q;

    // qualified requests, overflow and underflow are dropped here
    logic do_push;
    logic do_pop;

    assign full_o  = (int'(fill_q) == dma_cfg_pkg::BUFFER_DEPTH);
    assign empty_o = (fill_q == '0);
    assign do_push = push_i & ~full_o;
    assign do_pop  = pop_i & ~empty_o;

    // oldest entry
    assign data_o  = mem_q[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            fill_q   <= '0;
        end else begin
            // pointers wrap at the depth, which need not be a power of two
            if (do_push) begin
                wr_ptr_q <= (int'(wr_ptr_q) == dma_cfg_pkg::BUFFER_DEPTH - 1) ?
                            '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (int'(rd_ptr_q) == dma_cfg_pkg::BUFFER_DEPTH - 1) ?
                            '0 : rd_ptr_q + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   fill_q <= fill_q + 1'b1;
                2'b01:   fill_q <= fill_q - 1'b1;
                default: fill_q <= fill_q;
            endcase
        end
    end

endmodule

// File: rtl/dma_read_align.sv
// ----------------------------------------------------------------------
// read side of the data path: masks the valid bytes of each read beat,
// rotates them into write alignment and pushes them into the byte lanes
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module dma_read_align (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    // read channel
    input  dma_chan_pkg::r_beat_t   r_beat_i,
    input  logic                    r_valid_i,
    output logic                    r_ready_o,
    // read request, held for the whole burst
    input  logic                    r_dp_valid_i,
    output logic                    r_dp_ready_o,
    input  dma_chan_pkg::r_align_t  r_align_i,
    // lane bank
    input  dma_chan_pkg::lane_mask_t lane_full_i,
    output dma_chan_pkg::lane_mask_t lane_push_o,
    output dma_chan_pkg::lane_data_t lane_wdata_o
);

    // sticky first-beat flag, set between bursts
    logic first_q;

    // valid bytes in read alignment, then rotated into lanes
    dma_chan_pkg::lane_mask_t rd_mask;
    dma_chan_pkg::lane_mask_t in_mask;
    dma_chan_pkg::lane_data_t rot_data;

    logic blocked;
    logic accept;

    // ------------------------------------------------------------------
    // valid byte mask
    // ------------------------------------------------------------------
    always_comb begin
        rd_mask = '1;
        // leading bytes before the read offset are junk
        if (first_q) begin
            rd_mask = rd_mask & dma_cfg_pkg::first_mask(r_align_i.offset);
        end
        // trailing bytes past the tailer are junk
        if (r_beat_i.last) begin
            rd_mask = rd_mask & dma_cfg_pkg::last_mask(r_align_i.tailer);
        end
    end

    // ------------------------------------------------------------------
    // barrel shifter
    // ------------------------------------------------------------------
    // read byte i goes to lane (i + shift) mod 4, the mask follows
    always_comb begin
        logic [dma_cfg_pkg::OFFSET_WIDTH-1:0] lane;
        rot_data = '0;
        in_mask  = '0;
        for (int i = 0; i < dma_cfg_pkg::BYTES_PER_BEAT; i++) begin
            // natural wrap of the 2-bit index
            lane           = dma_cfg_pkg::OFFSET_WIDTH'(r_align_i.shift + i);
            rot_data[lane] = r_beat_i.data[i];
            in_mask[lane]  = rd_mask[i];
        end
    end

    // ------------------------------------------------------------------
    // push control
    // ------------------------------------------------------------------
    // stall only if a lane that this beat writes is full
    assign blocked      = |(lane_full_i & in_mask);
    assign r_ready_o    = ~blocked;
    assign accept       = r_valid_i & ~blocked;

    assign lane_push_o  = accept ? in_mask : '0;
    assign lane_wdata_o = rot_data;

    // request done with the last read beat
    assign r_dp_ready_o = r_dp_valid_i & accept & r_beat_i.last;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            first_q <= 1'b1;
        end else if (accept) begin
            // next beat is a first one only after a last one
            first_q <= r_beat_i.last;
        end
    end

endmodule

// File: rtl/dma_write_beat.sv
// ----------------------------------------------------------------------
// write side of the data path: builds the strobe for each write beat,
// pops the strobed lanes and tracks the burst to place w_last
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module dma_write_beat (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    // write request, held for the whole burst
    input  dma_chan_pkg::w_align_t   w_align_i,
    output logic                     w_dp_ready_o,
    // write channel
    input  logic                     w_ready_i,
    output logic                     w_valid_o,
    output dma_chan_pkg::w_beat_t    w_beat_o,
    // lane bank
    input  dma_chan_pkg::lane_mask_t lane_empty_i,
    input  dma_chan_pkg::lane_data_t lane_rdata_i,
    output dma_chan_pkg::lane_mask_t lane_pop_o
);

    // write alignment masks of the current request
    dma_chan_pkg::lane_mask_t first_m;
    dma_chan_pkg::lane_mask_t last_m;
    dma_chan_pkg::lane_mask_t strb;
    dma_chan_pkg::lane_mask_t filled;

    // beat position within the burst
    logic is_first;
    logic is_last;
    logic first_possible;

    logic ready_to_write;
    logic w_hs;

    // remaining beats, valid from the first handshake of a burst
    logic [dma_cfg_pkg::BEAT_CNT_WIDTH-1:0] cnt_q;
    logic                                   cnt_valid_q;

    assign first_m = dma_cfg_pkg::first_mask(w_align_i.offset);
    assign last_m  = dma_cfg_pkg::last_mask(w_align_i.tailer);
    assign filled  = ~lane_empty_i;

    // lanes of a first beat hold data, so the first read beat has landed
    assign first_possible = ((filled & first_m) == first_m);

    // ------------------------------------------------------------------
    // strobe generation
    // ------------------------------------------------------------------
    always_comb begin
        if (w_align_i.single) begin
            // one beat is both ends of the transfer
            is_first = 1'b1;
            is_last  = 1'b1;
        end else begin
            is_first = first_possible & ~cnt_valid_q;
            is_last  = cnt_valid_q & (cnt_q == dma_cfg_pkg::BEAT_CNT_WIDTH'(1));
        end

        strb = '1;
        if (is_first) begin
            strb = strb & first_m;
        end
        if (is_last) begin
            strb = strb & last_m;
        end
    end

    // every strobed lane must hold a byte
    assign ready_to_write = ((filled & strb) == strb);
    assign w_valid_o      = ready_to_write;
    assign w_hs           = ready_to_write & w_ready_i;
    assign lane_pop_o     = w_hs ? strb : '0;

    // ------------------------------------------------------------------
    // bus outputs
    // ------------------------------------------------------------------
    // data and strobe stay zero unless a beat actually moves
    always_comb begin
        w_beat_o = '0;
        if (w_hs) begin
            for (int i = 0; i < dma_cfg_pkg::BYTES_PER_BEAT; i++) begin
                w_beat_o.data[i] = strb[i] ? lane_rdata_i[i] : '0;
            end
            w_beat_o.strb = strb;
            w_beat_o.last = is_last;
        end
    end

    assign w_dp_ready_o = is_last & w_hs;

    // ------------------------------------------------------------------
    // burst counter
    // ------------------------------------------------------------------
    // loaded with the beats left after the first one, last at one
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cnt_q       <= '0;
            cnt_valid_q <= 1'b0;
        end else if (w_hs && !w_align_i.single) begin
            if (cnt_valid_q) begin
                cnt_q       <= cnt_q - 1'b1;
                cnt_valid_q <= ~is_last;
            end else if (is_first) begin
                cnt_q       <= w_align_i.num_beats - 1'b1;
                cnt_valid_q <= 1'b1;
            end
        end
    end

endmodule

// File: rtl/dma_data_path.sv
// ----------------------------------------------------------------------
// DMA data path top: read beats are realigned through a bank of byte
// lane FIFOs and leave as write beats with offset and tailer strobes
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module dma_data_path (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    // read channel
    input  dma_chan_pkg::r_beat_t  r_beat_i,
    input  logic                   r_valid_i,
    output logic                   r_ready_o,
    // read request
    input  logic                   r_dp_valid_i,
    output logic                   r_dp_ready_o,
    input  dma_chan_pkg::r_align_t r_align_i,
    // write channel
    output dma_chan_pkg::w_beat_t  w_beat_o,
    output logic                   w_valid_o,
    input  logic                   w_ready_i,
    // write request
    input  logic                   w_dp_valid_i,
    output logic                   w_dp_ready_o,
    input  dma_chan_pkg::w_align_t w_align_i,
    // status
    output logic                   data_path_idle_o
);

    // lane bank interface
    dma_chan_pkg::lane_mask_t lane_push;
    dma_chan_pkg::lane_data_t lane_wdata;
    dma_chan_pkg::lane_mask_t lane_full;
    dma_chan_pkg::lane_mask_t lane_pop;
    dma_chan_pkg::lane_data_t lane_rdata;
    dma_chan_pkg::lane_mask_t lane_empty;

    dma_read_align u_read_align (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .r_beat_i     (r_beat_i),
        .r_valid_i    (r_valid_i),
        .r_ready_o    (r_ready_o),
        .r_dp_valid_i (r_dp_valid_i),
        .r_dp_ready_o (r_dp_ready_o),
        .r_align_i    (r_align_i),
        .lane_full_i  (lane_full),
        .lane_push_o  (lane_push),
        .lane_wdata_o (lane_wdata)
    );

    // ------------------------------------------------------------------
    // lane bank, one FIFO per byte lane
    // ------------------------------------------------------------------
    for (genvar i = 0; i < dma_cfg_pkg::BYTES_PER_BEAT; i++) begin : g_lane
        dma_byte_fifo u_byte_fifo (
            .clk_i   (clk_i),
            .rst_ni  (rst_ni),
            .push_i  (lane_push[i]),
            .data_i  (lane_wdata[i]),
            .pop_i   (lane_pop[i]),
            .data_o  (lane_rdata[i]),
            .full_o  (lane_full[i]),
            .empty_o (lane_empty[i])
        );
    end

    dma_write_beat u_write_beat (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .w_align_i    (w_align_i),
        .w_dp_ready_o (w_dp_ready_o),
        .w_ready_i    (w_ready_i),
        .w_valid_o    (w_valid_o),
        .w_beat_o     (w_beat_o),
        .lane_empty_i (lane_empty),
        .lane_rdata_i (lane_rdata),
        .lane_pop_o   (lane_pop)
    );

    // no request open or closing on either side and nothing buffered
    assign data_path_idle_o = ~(r_dp_valid_i | r_dp_ready_o | w_dp_valid_i | w_dp_ready_o)
                              & (&lane_empty);

endmodule

// File: test/tb_dma_data_path.sv
// ----------------------------------------------------------------------
// testbench for the DMA data path that drives read bursts with random
// alignment, gaps and write back-pressure and checks every write beat
// against a byte-level model of the realignment
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module tb_dma_data_path;

    // watchdog cycles allowed per beat under random stalls
    localparam int STALL_FACTOR = 8;
    localparam int NUM_RANDOM   = 8;

    logic                   clk_i;
    logic                   rst_ni;
    dma_chan_pkg::r_beat_t  r_beat_i;
    logic                   r_valid_i;
    logic                   r_ready_o;
    logic                   r_dp_valid_i;
    logic                   r_dp_ready_o;
    dma_chan_pkg::r_align_t r_align_i;
    dma_chan_pkg::w_beat_t  w_beat_o;
    logic                   w_valid_o;
    logic                   w_ready_i;
    logic                   w_dp_valid_i;
    logic                   w_dp_ready_o;
    dma_chan_pkg::w_align_t w_align_i;
    logic                   data_path_idle_o;

    integer seed = 32'h513e;
    int     err_cnt;
    int     test_cnt;
    int     fail_cnt;
    // current transfer as seen by the compare process
    int     cur_len;
    int     cur_wo;
    int     cur_tid;
    int     cur_rbeats;
    int     rd_idx;
    int     wr_idx;
    int     r_dp_cnt;
    int     w_dp_cnt;
    bit     saw_stall;
    // watchdog state
    bit     active;
    int     cyc;
    int     budget;

    dma_data_path u_dma_data_path (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .r_beat_i         (r_beat_i),
        .r_valid_i        (r_valid_i),
        .r_ready_o        (r_ready_o),
        .r_dp_valid_i     (r_dp_valid_i),
        .r_dp_ready_o     (r_dp_ready_o),
        .r_align_i        (r_align_i),
        .w_beat_o         (w_beat_o),
        .w_valid_o        (w_valid_o),
        .w_ready_i        (w_ready_i),
        .w_dp_valid_i     (w_dp_valid_i),
        .w_dp_ready_o     (w_dp_ready_o),
        .w_align_i        (w_align_i),
        .data_path_idle_o (data_path_idle_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    task automatic check_val(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got %h expected %h at %0t", name, got, exp, $time);
            err_cnt++;
        end
    endtask

    // ------------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------------
    // source byte k of a transfer mixes the whole index with the test id
    function automatic logic [7:0] src_byte(input int tid, input int k);
        return 8'((k & 255) ^ (k >> 8) ^ (tid * 37 + 11));
    endfunction

    function automatic int beat_count(input int offset, input int len);
        return (offset + len + 3) / 4;
    endfunction

    function automatic dma_chan_pkg::r_align_t make_r_align(input int len, input int ro,
                                                            input int wo);
        dma_chan_pkg::r_align_t a;
        a.offset = dma_cfg_pkg::OFFSET_WIDTH'(ro);
        a.tailer = dma_cfg_pkg::OFFSET_WIDTH'((ro + len) % 4);
        a.shift  = dma_cfg_pkg::OFFSET_WIDTH'((wo - ro + 4) % 4);
        return a;
    endfunction

    function automatic dma_chan_pkg::w_align_t make_w_align(input int len, input int wo);
        dma_chan_pkg::w_align_t a;
        a.offset    = dma_cfg_pkg::OFFSET_WIDTH'(wo);
        a.tailer    = dma_cfg_pkg::OFFSET_WIDTH'((wo + len) % 4);
        a.num_beats = dma_cfg_pkg::BEAT_CNT_WIDTH'(beat_count(wo, len));
        a.single    = (beat_count(wo, len) == 1);
        return a;
    endfunction

    // read beat rb where bytes outside the transfer carry junk
    function automatic dma_chan_pkg::r_beat_t read_beat(input int len, input int ro,
                                                        input int tid, input int rb,
                                                        input logic [31:0] junk);
        dma_chan_pkg::r_beat_t beat;
        int k;
        beat.data = junk;
        for (int i = 0; i < 4; i++) begin
            k = rb * 4 + i - ro;
            if (k >= 0 && k < len) begin
                beat.data[i] = src_byte(tid, k);
            end
        end
        beat.last = (rb == beat_count(ro, len) - 1);
        return beat;
    endfunction

    // write beat wb holds the same byte stream placed from lane wo
    function automatic dma_chan_pkg::w_beat_t expect_beat(input int len, input int wo,
                                                          input int tid, input int wb);
        dma_chan_pkg::w_beat_t beat;
        int k;
        beat = '0;
        for (int j = 0; j < 4; j++) begin
            k = wb * 4 + j - wo;
            if (k >= 0 && k < len) begin
                beat.data[j] = src_byte(tid, k);
                beat.strb[j] = 1'b1;
            end
        end
        beat.last = (wb == beat_count(wo, len) - 1);
        return beat;
    endfunction

    // ------------------------------------------------------------------
    // compare process sampling on the falling edge
    // ------------------------------------------------------------------
    always @(negedge clk_i) begin : compare
        dma_chan_pkg::w_beat_t exp_beat;
        logic                  exp_rdp;
        if (rst_ni) begin
            if (r_valid_i && !r_ready_o) begin
                saw_stall = 1'b1;
            end
            // request done exactly with the final read beat of the burst
            if (r_valid_i && r_ready_o) begin
                exp_rdp = (rd_idx == cur_rbeats - 1);
                rd_idx++;
            end else begin
                exp_rdp = 1'b0;
            end
            check_val("r_dp_ready_o", 64'(r_dp_ready_o), 64'(exp_rdp));
            if (r_dp_ready_o) begin
                r_dp_cnt++;
            end
            if (w_valid_o && w_ready_i) begin
                exp_beat = expect_beat(cur_len, cur_wo, cur_tid, wr_idx);
                check_val("w_beat_o", 64'(w_beat_o), 64'(exp_beat));
                check_val("w_dp_ready_o", 64'(w_dp_ready_o), 64'(exp_beat.last));
                wr_idx++;
            end else begin
                check_val("w_beat_o", 64'(w_beat_o), 64'(0));
                check_val("w_dp_ready_o", 64'(w_dp_ready_o), 64'(0));
            end
            if (w_dp_ready_o) begin
                w_dp_cnt++;
            end
        end
    end

    // watchdog with a limit set per transfer from its beat counts
    always @(posedge clk_i) begin
        if (active) begin
            cyc++;
            if (cyc > budget) begin
                $display("transfer %0d stalled, no completion within %0d cycles",
                         cur_tid, budget);
                $display(">>> FAIL");
                $finish;
            end
        end
    end

    // ------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------
    task automatic drive_reads(input int len, input int ro, input int tid, input bit gaps);
        int rb;
        bit taken;
        rb = 0;
        while (rb < beat_count(ro, len)) begin
            if (gaps && ($random(seed) & 3) == 0) begin
                r_valid_i <= 1'b0;
                @(posedge clk_i);
            end else begin
                r_beat_i  <= read_beat(len, ro, tid, rb, $random(seed));
                r_valid_i <= 1'b1;
                taken = 1'b0;
                while (!taken) begin
                    @(negedge clk_i);
                    taken = r_ready_o;
                    @(posedge clk_i);
                end
                rb++;
            end
        end
        r_valid_i <= 1'b0;
    endtask

    // hold ready low first, then optionally drop it at random
    task automatic drive_w_ready(input int wbeats, input int hold, input bit rnd);
        int n;
        n = 0;
        while (wr_idx < wbeats) begin
            if (n < hold) begin
                w_ready_i <= 1'b0;
            end else if (rnd) begin
                w_ready_i <= (($random(seed) & 3) != 0);
            end else begin
                w_ready_i <= 1'b1;
            end
            n++;
            @(posedge clk_i);
        end
        w_ready_i <= 1'b0;
    endtask

    task automatic run_transfer(input string name, input int len, input int ro,
                                input int wo, input bit gaps, input int hold,
                                input bit rnd_ready);
        int wbeats;
        int errs_before;
        wbeats      = beat_count(wo, len);
        errs_before = err_cnt;
        test_cnt++;
        cur_len    = len;
        cur_wo     = wo;
        cur_tid    = test_cnt;
        cur_rbeats = beat_count(ro, len);
        rd_idx     = 0;
        wr_idx     = 0;
        r_dp_cnt   = 0;
        w_dp_cnt   = 0;
        saw_stall  = 1'b0;
        cyc        = 0;
        budget     = (cur_rbeats + wbeats) * STALL_FACTOR + hold + 16;
        active     = 1'b1;
        @(posedge clk_i);
        r_align_i    <= make_r_align(len, ro, wo);
        w_align_i    <= make_w_align(len, wo);
        r_dp_valid_i <= 1'b1;
        w_dp_valid_i <= 1'b1;
        fork
            drive_reads(len, ro, test_cnt, gaps);
            drive_w_ready(wbeats, hold, rnd_ready);
        join
        r_dp_valid_i <= 1'b0;
        w_dp_valid_i <= 1'b0;
        @(negedge clk_i);
        active = 1'b0;
        check_val("data_path_idle_o", 64'(data_path_idle_o), 64'(1));
        check_val("r_dp_ready_o pulses", 64'(r_dp_cnt), 64'(1));
        check_val("w_dp_ready_o pulses", 64'(w_dp_cnt), 64'(1));
        check_val("write beats", 64'(wr_idx), 64'(wbeats));
        if (hold > 0 && !saw_stall) begin
            $display("r_ready_o never went low while the write side was stalled");
            err_cnt++;
        end
        if (err_cnt == errs_before) begin
            $display("test %0d %s (len %0d ro %0d wo %0d): ok", test_cnt, name, len, ro, wo);
        end else begin
            $display("test %0d %s (len %0d ro %0d wo %0d): %0d errors", test_cnt, name,
                     len, ro, wo, err_cnt - errs_before);
            fail_cnt++;
        end
    endtask

    initial begin
        int len;
        int ro;
        int wo;
        rst_ni       = 1'b0;
        r_beat_i     = '0;
        r_valid_i    = 1'b0;
        r_dp_valid_i = 1'b0;
        r_align_i    = '0;
        w_ready_i    = 1'b0;
        w_dp_valid_i = 1'b0;
        w_align_i    = '0;
        repeat (2) @(posedge clk_i);
        rst_ni <= 1'b1;
        @(negedge clk_i);

        // state straight after reset
        test_cnt++;
        check_val("w_valid_o", 64'(w_valid_o), 64'(0));
        check_val("r_ready_o", 64'(r_ready_o), 64'(1));
        check_val("data_path_idle_o", 64'(data_path_idle_o), 64'(1));
        if (err_cnt == 0) begin
            $display("test %0d reset state: ok", test_cnt);
        end else begin
            $display("test %0d reset state: %0d errors", test_cnt, err_cnt);
            fail_cnt++;
        end

        run_transfer("aligned burst", 16, 0, 0, 1'b0, 0, 1'b0);
        run_transfer("more read than write beats", 6, 3, 0, 1'b0, 0, 1'b0);
        run_transfer("more write than read beats", 6, 0, 3, 1'b0, 0, 1'b0);
        for (int t = 0; t < NUM_RANDOM; t++) begin
            ro  = $random(seed) & 3;
            wo  = $random(seed) & 3;
            len = 1 + ($random(seed) & 31);
            run_transfer("random alignment", len, ro, wo, 1'b0, 0, 1'b0);
        end
        run_transfer("single write beat", 3, 2, 1, 1'b0, 0, 1'b0);
        run_transfer("single byte", 1, 3, 0, 1'b0, 0, 1'b0);
        run_transfer("gaps and back-pressure", 40, 1, 3, 1'b1, 12, 1'b1);

        $display("tests %0d, failed %0d, check errors %0d", test_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: list.f
rtl/dma_cfg_pkg.sv
rtl/dma_chan_pkg.sv
rtl/dma_byte_fifo.sv
rtl/dma_read_align.sv
rtl/dma_write_beat.sv
rtl/dma_data_path.sv
test/tb_dma_data_path.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the DMA data path testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f list.f --top-module tb_dma_data_path \
    -Mdir obj_dir -o tb_dma_data_path > build.log 2>&1 \
    && ./obj_dir/tb_dma_data_path > sim.log 2>&1 \
    || { cat build.log; echo "build or simulation error"; exit 1; }

cat sim.log
grep -q ">>> FAIL" sim.log && exit 1
grep -q ">>> PASS" sim.log || exit 1
exit 0
